// ==== build.f ====
+incdir+source
source/mem_system_pkg.sv
source/cache_way.sv
source/banked_memory.sv
source/cache_controller.sv
source/mem_system.sv
dv/mem_system_tb.sv

// ==== Bender.yml ====
package:
  name: mem_system

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mem_system_pkg.sv
      - source/cache_way.sv
      - source/banked_memory.sv
      - source/cache_controller.sv
      - source/mem_system.sv
  - target: test
    files:
      - dv/mem_system_tb.sv

// ==== dv/mem_system_tb.sv ====
//**************************************************************************
// Directed testbench for the two-way cache system.
// A reference model keeps tags, valid and dirty bits, the victim bit and
// the memory contents as the requester sees them. data_out is checked on
// reads only, since during a write it shows the word before the write.
//**************************************************************************
`timescale 1ns/1ps

module mem_system_tb;
   import mem_system_pkg::*;

   localparam int half_period     = 50;
   localparam int drive_delay     = 1;
   localparam int reset_cycles    = 8;
   localparam int hit_latency     = 1;
   localparam int clean_latency   = 9;
   localparam int dirty_latency   = 13;
   localparam int done_wait_limit = 20;
   localparam int n_random        = 150;
   // About 170 requests at up to 15 cycles each, plus reset and margin
   localparam int max_cycles      = 4000;

   typedef enum int {k_hit, k_clean, k_dirty, k_misaligned, k_any} access_kind_t;

   // Expected response of one request
   typedef struct packed {
      logic       hit;
      logic       err;
      logic       check_data;
      word_t      data;
      logic [7:0] latency;
   } expect_t;

   logic  clk = 1'b0;
   logic  reset;
   addr_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   int    cycle_count = 0;
   int    error_count = 0;
   int    check_count = 0;

   // Reference model of both ways and of memory
   tag_t  m_tag   [2][256];
   logic  m_valid [2][256];
   logic  m_dirty [2][256];
   logic  m_victim;
   word_t m_mem   [addr_t];

   mem_system mem_system_i (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   // 100 ns clock
   always #half_period clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   initial begin
      wait (cycle_count >= max_cycles);
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("*** FAILED ***");
      $finish;
   end

   function automatic addr_t line_addr(input tag_t tg, input index_t idx,
                                       input logic [1:0] word);
      return {tg, idx, word, 1'b0};
   endfunction

   // Predicts one access, then updates the model as the cache would
   task automatic model_access(input logic is_wr, input addr_t a, input word_t d,
                               output access_kind_t kind, output expect_t exp);
      index_t idx;
      tag_t   tg;
      int     way;
      idx = a[10:3];
      tg  = a[15:11];
      exp = '0;
      exp.latency = hit_latency;
      if (a[0]) begin
         kind = k_misaligned;
         exp.err = 1'b1;
      end else begin
         way = -1;
         for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && (m_tag[w][idx] == tg)) begin
               way = w;
            end
         end
         if (way >= 0) begin
            kind = k_hit;
            exp.hit = 1'b1;
         end else begin
            // Invalid way first, way 0 before way 1
            if (!m_valid[0][idx]) begin
               way = 0;
            end else if (!m_valid[1][idx]) begin
               way = 1;
            end else begin
               way = m_victim;
            end
            kind = (m_valid[way][idx] && m_dirty[way][idx]) ? k_dirty : k_clean;
            exp.latency = (kind == k_dirty) ? dirty_latency : clean_latency;
            m_tag[way][idx]   = tg;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
         end
         exp.check_data = !is_wr;
         exp.data = m_mem.exists(a) ? m_mem[a] : '0;
         if (is_wr) begin
            m_mem[a] = d;
            m_dirty[way][idx] = 1'b1;
         end
         m_victim = !m_victim;
      end
   endtask

   // Drives one request from just after a rising edge and waits for done
   task automatic run_request(input logic is_wr, input addr_t a, input word_t d,
                              input expect_t exp);
      int lat;
      addr    = a;
      data_in = d;
      rd      = !is_wr;
      wr      = is_wr;
      lat     = 0;
      @(negedge clk);
      while (!done && (lat < done_wait_limit)) begin
         assert (exp.err || !err) else begin
            error_count++;
            $display("ERR err: got %h, expected 0 while waiting, address %h", err, a);
         end
         assert (stall) else begin
            error_count++;
            $display("ERR stall: got %h, expected 1 while waiting, address %h", stall, a);
         end
         @(negedge clk);
         lat++;
      end
      assert (done) else begin
         error_count++;
         $display("No done within %0d cycles for the request to address %h",
                  done_wait_limit, a);
      end
      if (done) begin
         check_count++;
         assert (lat == exp.latency) else begin
            error_count++;
            $display("ERR latency: got %h, expected %h, address %h", lat, exp.latency, a);
         end
         assert (cache_hit == exp.hit) else begin
            error_count++;
            $display("ERR cache_hit: got %h, expected %h, address %h", cache_hit, exp.hit, a);
         end
         assert (err == exp.err) else begin
            error_count++;
            $display("ERR err: got %h, expected %h, address %h", err, exp.err, a);
         end
         assert (!stall) else begin
            error_count++;
            $display("ERR stall: got %h, expected 0 with done, address %h", stall, a);
         end
         if (exp.check_data) begin
            assert (data_out == exp.data) else begin
               error_count++;
               $display("ERR data_out: got %h, expected %h, address %h",
                        data_out, exp.data, a);
            end
         end
      end
      @(posedge clk);
      #drive_delay;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   task automatic issue_access(input logic is_wr, input addr_t a, input word_t d,
                               input access_kind_t want);
      access_kind_t kind;
      expect_t      exp;
      model_access(is_wr, a, d, kind, exp);
      assert ((want == k_any) || (kind == want)) else begin
         error_count++;
         $display("Model predicts another outcome than the test intends, address %h", a);
      end
      run_request(is_wr, a, d, exp);
   endtask

   task automatic idle_after_reset();
      repeat (5) begin
         @(negedge clk);
         assert (!done && !stall && !cache_hit && !err) else begin
            error_count++;
            $display("ERR done stall cache_hit err: got %h %h %h %h, expected 0 0 0 0",
                     done, stall, cache_hit, err);
         end
      end
      @(posedge clk);
      #drive_delay;
   endtask

   task automatic miss_then_hit();
      issue_access(1'b1, line_addr(5'd1, 8'h10, 2'd2), 16'hbeef, k_clean);
      issue_access(1'b0, line_addr(5'd1, 8'h10, 2'd2), 16'h0000, k_hit);
      issue_access(1'b0, line_addr(5'd1, 8'h10, 2'd0), 16'h0000, k_hit);
   endtask

   task automatic two_way_replacement();
      issue_access(1'b0, line_addr(5'd2, 8'h20, 2'd1), 16'h0000, k_clean);
      issue_access(1'b0, line_addr(5'd3, 8'h20, 2'd1), 16'h0000, k_clean);
      issue_access(1'b0, line_addr(5'd4, 8'h20, 2'd1), 16'h0000, k_clean);
      // The model knows which of the first two tags was evicted
      issue_access(1'b0, line_addr(5'd2, 8'h20, 2'd1), 16'h0000, k_any);
      issue_access(1'b0, line_addr(5'd3, 8'h20, 2'd1), 16'h0000, k_any);
   endtask

   task automatic dirty_writeback();
      issue_access(1'b1, line_addr(5'd5, 8'h30, 2'd1), 16'h1234, k_clean);
      issue_access(1'b1, line_addr(5'd6, 8'h30, 2'd2), 16'h5678, k_clean);
      issue_access(1'b0, line_addr(5'd7, 8'h30, 2'd3), 16'h0000, k_dirty);
      // The evicted word comes back from memory
      issue_access(1'b0, line_addr(5'd5, 8'h30, 2'd1), 16'h0000, k_any);
      issue_access(1'b0, line_addr(5'd6, 8'h30, 2'd2), 16'h0000, k_any);
   endtask

   task automatic random_mix();
      addr_t a;
      word_t d;
      logic  is_wr;
      for (int i = 0; i < n_random; i++) begin
         a = line_addr(tag_t'($urandom % 4), index_t'(8'h40 + ($urandom % 3)),
                       2'($urandom % 4));
         d = word_t'($urandom);
         is_wr = 1'($urandom % 2);
         issue_access(is_wr, a, d, k_any);
      end
   endtask

   task automatic misaligned_request();
      issue_access(1'b1, line_addr(5'd8, 8'h50, 2'd0), 16'hcafe, k_clean);
      issue_access(1'b0, line_addr(5'd9, 8'h50, 2'd0), 16'h0000, k_clean);
      issue_access(1'b1, line_addr(5'd8, 8'h50, 2'd0) | 16'h0001, 16'hdead, k_misaligned);
      issue_access(1'b0, line_addr(5'd8, 8'h50, 2'd0), 16'h0000, k_hit);
      // Latency shows the victim since way 0 is dirty and way 1 clean
      issue_access(1'b0, line_addr(5'd10, 8'h50, 2'd0), 16'h0000, k_any);
   endtask

   initial begin
      void'($urandom(32'h1deb4c69));
      reset   = 1'b1;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      m_victim = 1'b0;
      for (int w = 0; w < 2; w++) begin
         for (int i = 0; i < 256; i++) begin
            m_tag[w][i]   = '0;
            m_valid[w][i] = 1'b0;
            m_dirty[w][i] = 1'b0;
         end
      end
      repeat (reset_cycles) @(posedge clk);
      #drive_delay;
      reset = 1'b0;

      idle_after_reset();
      miss_then_hit();
      two_way_replacement();
      dirty_writeback();
      random_mix();
      misaligned_request();

      $display("Requests checked: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== source/mem_system.sv ====
//**************************************************************************
// Two-way set-associative data cache in front of a four-bank memory.
// Requester holds rd or wr until done pulses, never both at once.
// stall is high while a request is open and done is low.
//**************************************************************************
`timescale 1ns/1ps

module mem_system (
   input  logic                  clk,
   input  logic                  reset,
   input  mem_system_pkg::addr_t addr,
   input  mem_system_pkg::word_t data_in,
   input  logic                  rd,
   input  logic                  wr,
   output mem_system_pkg::word_t data_out,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err
);
   import mem_system_pkg::*;

   way_req_t way_req0;
   way_req_t way_req1;
   way_rsp_t way_rsp0;
   way_rsp_t way_rsp1;
   mem_req_t mem_req;
   word_t    mem_rd_data;
   logic     mem_err;

   cache_controller controller (
      .clk         (clk),
      .reset       (reset),
      .rd          (rd),
      .wr          (wr),
      .addr        (addr),
      .data_in     (data_in),
      .way_rsp0    (way_rsp0),
      .way_rsp1    (way_rsp1),
      .mem_rd_data (mem_rd_data),
      .mem_err     (mem_err),
      .way_req0    (way_req0),
      .way_req1    (way_req1),
      .mem_req     (mem_req),
      .data_out    (data_out),
      .done        (done),
      .stall       (stall),
      .cache_hit   (cache_hit),
      .err         (err)
   );

   cache_way way0 (
      .clk   (clk),
      .reset (reset),
      .req   (way_req0),
      .rsp   (way_rsp0)
   );

   cache_way way1 (
      .clk   (clk),
      .reset (reset),
      .req   (way_req1),
      .rsp   (way_rsp1)
   );

   banked_memory mem (
      .clk     (clk),
      .reset   (reset),
      .req     (mem_req),
      .rd_data (mem_rd_data),
      .err     (mem_err)
   );

endmodule

// ==== source/cache_controller.sv ====
//**************************************************************************
// Cache FSM: hit check, victim choice, writeback, refill and replay.
// The requester must hold rd or wr with addr and data_in until done.
// Hit takes 1 cycle, clean miss 9 and dirty miss 13. A misaligned
// request ends in 1 cycle with err and leaves the cache untouched.
//**************************************************************************
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_controller (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     rd,
   input  logic                     wr,
   input  logic [`ADDR_W-1:0]       addr,
   input  logic [`DATA_W-1:0]       data_in,
   input  mem_system_pkg::way_rsp_t way_rsp0,
   input  mem_system_pkg::way_rsp_t way_rsp1,
   input  logic [`DATA_W-1:0]       mem_rd_data,
   input  logic                     mem_err,
   output mem_system_pkg::way_req_t way_req0,
   output mem_system_pkg::way_req_t way_req1,
   output mem_system_pkg::mem_req_t mem_req,
   output logic [`DATA_W-1:0]       data_out,
   output logic                     done,
   output logic                     stall,
   output logic                     cache_hit,
   output logic                     err
);
   import mem_system_pkg::*;

   localparam int off_w = $bits(offset_t);

   ctrl_state_t state;
   ctrl_state_t next_state;
   way_req_t    way_cmd;
   way_rsp_t    rsp0_q;
   way_rsp_t    rsp1_q;
   way_rsp_t    victim_rsp;
   tag_t        req_tag;
   index_t      req_index;
   offset_t     req_offset;
   offset_t     mem_word;
   offset_t     fill_word;
   logic [1:0]  way_en;
   logic [1:0]  victim_mask;
   logic        aligned;
   logic        hit_any;
   logic        victim_bit;
   logic        victim_sel;
   logic        victim_q;
   logic        victim_dirty;
   logic        misalign_err;

   assign req_tag    = addr[`ADDR_W-1 -: `CACHE_TAG_W];
   assign req_index  = addr[off_w+1 +: `CACHE_INDEX_W];
   assign req_offset = addr[1 +: off_w];
   assign aligned    = ~addr[0];

   // Responses of the compare cycle, used one cycle later
   always_ff @(posedge clk) begin
      rsp0_q <= way_rsp0;
      rsp1_q <= way_rsp1;
   end

   assign hit_any = rsp0_q.hit | rsp1_q.hit;

   // An invalid way goes first, else the round-robin bit decides
   assign victim_sel   = !rsp0_q.valid ? 1'b0 : (!rsp1_q.valid ? 1'b1 : victim_bit);
   assign victim_dirty = victim_sel ? (rsp1_q.valid & rsp1_q.dirty)
                                    : (rsp0_q.valid & rsp0_q.dirty);
   assign victim_mask  = victim_q ? 2'b10 : 2'b01;
   assign victim_rsp   = victim_q ? way_rsp1 : way_rsp0;

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= st_idle;
         victim_bit <= 1'b0;
         victim_q   <= 1'b0;
      end else begin
         state      <= next_state;
         victim_bit <= victim_bit ^ (done & aligned);
         if (state == st_check) begin
            victim_q <= victim_sel;
         end
      end
   end

   // Word handled by the memory side and by the fill side of each step
   always_comb begin
      case (state)
         st_wb1, st_rd1: mem_word = offset_t'(1);
         st_wb2, st_rd2: mem_word = offset_t'(2);
         st_wb3, st_rd3: mem_word = offset_t'(3);
         default:        mem_word = offset_t'(0);
      endcase
      case (state)
         st_rd3:   fill_word = offset_t'(1);
         st_fill2: fill_word = offset_t'(2);
         st_fill3: fill_word = offset_t'(3);
         default:  fill_word = offset_t'(0);
      endcase
   end

   always_comb begin
      next_state     = state;
      way_en         = 2'b00;
      way_cmd.enable = 1'b0;
      way_cmd.comp   = 1'b1;
      way_cmd.write  = 1'b0;
      way_cmd.tag    = req_tag;
      way_cmd.index  = req_index;
      way_cmd.offset = req_offset;
      way_cmd.data   = data_in;
      mem_req.rd     = 1'b0;
      mem_req.wr     = 1'b0;
      mem_req.addr   = {req_tag, req_index, mem_word, 1'b0};
      mem_req.data   = victim_rsp.data;

      case (state)
         st_idle: begin
            if (rd || wr) begin
               way_en        = {2{aligned}};
               way_cmd.write = wr;
               next_state    = st_check;
            end
         end
         st_check: begin
            if (!aligned || hit_any) begin
               next_state = st_idle;
            end else if (victim_dirty) begin
               next_state = st_wb0;
            end else begin
               next_state = st_rd0;
            end
         end
         st_wb0, st_wb1, st_wb2, st_wb3: begin
            // Read the old word and send it to memory in the same cycle
            way_en         = victim_mask;
            way_cmd.comp   = 1'b0;
            way_cmd.offset = mem_word;
            mem_req.wr     = 1'b1;
            mem_req.addr   = {victim_rsp.tag, req_index, mem_word, 1'b0};
            next_state     = ctrl_state_t'(state + 1'b1);
         end
         st_rd0, st_rd1, st_rd2, st_rd3: begin
            mem_req.rd = 1'b1;
            next_state = ctrl_state_t'(state + 1'b1);
         end
         st_fill2, st_fill3: begin
            next_state = ctrl_state_t'(state + 1'b1);
         end
         st_replay: begin
            way_en        = 2'b11;
            way_cmd.write = wr;
            next_state    = st_done;
         end
         default: begin
            next_state = st_idle;
         end
      endcase

      // Refill data arrives two cycles after each read
      if (state inside {st_rd2, st_rd3, st_fill2, st_fill3}) begin
         way_en         = victim_mask;
         way_cmd.comp   = 1'b0;
         way_cmd.write  = 1'b1;
         way_cmd.offset = fill_word;
         way_cmd.data   = mem_rd_data;
      end
   end

   always_comb begin
      way_req0        = way_cmd;
      way_req0.enable = way_en[0];
      way_req1        = way_cmd;
      way_req1.enable = way_en[1];
   end

   assign misalign_err = (state == st_check) && !aligned;
   assign done         = ((state == st_check) && (!aligned || hit_any)) || (state == st_done);
   assign cache_hit    = (state == st_check) && aligned && hit_any;
   assign err          = misalign_err | mem_err;
   assign stall        = (rd | wr) & ~done;
   assign data_out     = rsp1_q.hit ? rsp1_q.data : rsp0_q.data;

endmodule

// ==== source/banked_memory.sv ====
//**************************************************************************
// Four-bank word memory behind the cache, contents start at zero.
// Bank is picked by address bits 2:1. Read data appears a fixed latency
// after the request. A bank touched again while busy raises err for
// that cycle, and the access still takes place.
//**************************************************************************
`timescale 1ns/1ps
`include "cache_defs.svh"

module banked_memory (
   input  logic                     clk,
   input  logic                     reset,
   input  mem_system_pkg::mem_req_t req,
   output logic [`DATA_W-1:0]       rd_data,
   output logic                     err
);
   import mem_system_pkg::*;

   localparam int n_banks = 4;
   localparam int bank_w  = $clog2(n_banks);
   localparam int row_w   = `ADDR_W - 1 - bank_w;
   localparam int busy_w  = $clog2(`MEM_BANK_BUSY + 1);

   word_t             bank_mem [n_banks][2**row_w] = '{default: '0};
   word_t             rd_pipe  [`MEM_READ_LATENCY];
   logic [busy_w-1:0] busy_cnt [n_banks];
   logic [bank_w-1:0] bank;
   logic [row_w-1:0]  row;
   logic              access;

   assign bank   = req.addr[bank_w:1];
   assign row    = req.addr[`ADDR_W-1 -: row_w];
   assign access = req.rd | req.wr;
   assign err    = access && (busy_cnt[bank] != '0);

   always_ff @(posedge clk) begin
      if (req.wr) begin
         bank_mem[bank][row] <= req.data;
      end
   end

   // Read pipeline, first stage samples the array
   always_ff @(posedge clk) begin
      if (req.rd) begin
         rd_pipe[0] <= bank_mem[bank][row];
      end
      for (int s = 1; s < `MEM_READ_LATENCY; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   assign rd_data = rd_pipe[`MEM_READ_LATENCY-1];

   // Busy counters, reloaded on every access to the bank
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < n_banks; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < n_banks; b++) begin
            if (access && (bank == bank_w'(b))) begin
               busy_cnt[b] <= busy_w'(`MEM_BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

endmodule

// ==== source/cache_way.sv ====
//**************************************************************************
// One way of the cache: tag, valid, dirty and one line of words per index.
// Reads are combinational from the arrays, writes land at the clock edge.
// Only the valid bits are cleared by reset.
//**************************************************************************
`timescale 1ns/1ps

module cache_way (
   input  logic                     clk,
   input  logic                     reset,
   input  mem_system_pkg::way_req_t req,
   output mem_system_pkg::way_rsp_t rsp
);
   import mem_system_pkg::*;

   localparam int n_lines = 2 ** $bits(index_t);
   localparam int n_words = 2 ** $bits(offset_t);

   tag_t               tag_arr  [n_lines];
   word_t              data_arr [n_lines][n_words];
   logic [n_lines-1:0] valid_arr;
   logic [n_lines-1:0] dirty_arr;
   logic               tag_match;
   logic               hit;

   assign tag_match = (tag_arr[req.index] == req.tag);
   assign hit = req.enable && req.comp && valid_arr[req.index] && tag_match;

   always_comb begin
      rsp.hit   = hit;
      rsp.valid = valid_arr[req.index];
      rsp.dirty = dirty_arr[req.index];
      // Stored tag, needed to address a writeback
      rsp.tag   = tag_arr[req.index];
      rsp.data  = data_arr[req.index][req.offset];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_arr <= '0;
      end else if (req.enable && req.write && !req.comp) begin
         valid_arr[req.index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (req.enable && req.write) begin
         if (!req.comp) begin
            // Refill write, the line becomes clean with the new tag
            tag_arr[req.index] <= req.tag;
            data_arr[req.index][req.offset] <= req.data;
            dirty_arr[req.index] <= 1'b0;
         end else if (hit) begin
            data_arr[req.index][req.offset] <= req.data;
            dirty_arr[req.index] <= 1'b1;
         end
      end
   end

endmodule

// ==== source/mem_system_pkg.sv ====
//**************************************************************************
// Shared types of the cache system.
// The controller relies on the state order below and steps through the
// writeback and refill states by incrementing the state value.
//**************************************************************************
`include "cache_defs.svh"

package mem_system_pkg;

   typedef logic [`DATA_W-1:0]              word_t;
   typedef logic [`ADDR_W-1:0]              addr_t;
   typedef logic [`CACHE_TAG_W-1:0]         tag_t;
   typedef logic [`CACHE_INDEX_W-1:0]       index_t;
   typedef logic [$clog2(`LINE_WORDS)-1:0]  offset_t;

   // One access to a cache way
   typedef struct packed {
      logic    enable;
      logic    comp;
      logic    write;
      tag_t    tag;
      index_t  index;
      offset_t offset;
      word_t   data;
   } way_req_t;

   // Result of a way, valid in the same cycle as the request
   typedef struct packed {
      logic  hit;
      logic  valid;
      logic  dirty;
      tag_t  tag;
      word_t data;
   } way_rsp_t;

   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      word_t data;
   } mem_req_t;

   typedef enum logic [3:0] {
      st_idle, st_check,
      st_wb0, st_wb1, st_wb2, st_wb3,
      st_rd0, st_rd1, st_rd2, st_rd3,
      st_fill2, st_fill3,
      st_replay, st_done
   } ctrl_state_t;

endpackage

// ==== source/cache_defs.svh ====
//**************************************************************************
// Geometry and timing of the cache and its backing memory.
// Addresses are byte addresses of 16-bit words, so bit 0 must be zero.
// The bank count equals the line size, which lets one line touch each
// bank once.
//**************************************************************************
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define DATA_W             16
`define ADDR_W             16

// Address split is tag [15:11], index [10:3], word offset [2:1]
`define CACHE_TAG_W        5
`define CACHE_INDEX_W      8
`define LINE_WORDS         4

`define MEM_READ_LATENCY   2
`define MEM_BANK_BUSY      3

`endif
